// File: common/fetch_pkg.sv
package fetch_pkg;

	// boot image lives in the flash window
	localparam logic [31:0] reset_pc = 32'h3000_0000;

	// only the SDRAM window goes through the cache
	localparam logic [31:0] sdram_base = 32'ha000_0000;
	localparam logic [31:0] sdram_limit = 32'ha200_0000;

	localparam int line_bytes = 32;
	localparam int words_per_line = 8;
	localparam int line_count = 16;

	// address split is tag | index | offset
	localparam int offset_bits = 5;
	localparam int index_bits = 4;
	localparam int tag_bits = 23;

	typedef enum logic [2:0] {
		idle,
		lookup,
		miss_req,
		miss_fill,
		io_req,
		io_wait,
		hold,
		drain
	} fetch_state_t;

endpackage

// File: common/axi_pkg.sv
package axi_pkg;

	localparam logic [1:0] burst_fixed = 2'b00;
	localparam logic [1:0] burst_incr = 2'b01;

	localparam logic [1:0] resp_okay = 2'b00;

	// eight beats fill one cache line
	localparam logic [3:0] refill_len = 4'd7;

endpackage

// File: common/refill_if.sv
`timescale 1ns/100ps

interface refill_if;

	logic beat_valid;
	logic [31:0] beat_data;
	logic [fetch_pkg::tag_bits+fetch_pkg::index_bits-1:0] line_addr; // tag and index of the line
	logic [fetch_pkg::offset_bits-3:0] word_offset;
	logic last;

	modport ctrl(output beat_valid, beat_data, line_addr, input word_offset);

	modport counter(input beat_valid, output word_offset, last);

	modport array(input beat_valid, beat_data, line_addr, word_offset, last);

endinterface

// File: icache/icache_array.sv
`timescale 1ns/100ps

module icache_array (
	input logic clock,
	input logic reset,
	refill_if.array fill,
	input logic [31:0] lookup_addr,
	output logic lookup_hit,
	output logic [31:0] lookup_data
);

	logic [fetch_pkg::tag_bits-1:0] tags [fetch_pkg::line_count];
	logic [31:0] words [fetch_pkg::line_count][fetch_pkg::words_per_line];
	logic [fetch_pkg::line_count-1:0] valid;

	logic [fetch_pkg::tag_bits-1:0] rd_tag;
	logic [fetch_pkg::index_bits-1:0] rd_index;
	logic [fetch_pkg::offset_bits-3:0] rd_word;
	logic [fetch_pkg::tag_bits-1:0] wr_tag;
	logic [fetch_pkg::index_bits-1:0] wr_index;

	assign rd_tag = lookup_addr[31 -: fetch_pkg::tag_bits];
	assign rd_index = lookup_addr[fetch_pkg::offset_bits +: fetch_pkg::index_bits];
	assign rd_word = lookup_addr[fetch_pkg::offset_bits-1:2];
	assign {wr_tag, wr_index} = fill.line_addr;

	// a line being refilled stays invalid until its final word lands
	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
		end else if (fill.beat_valid) begin
			valid[wr_index] <= fill.last;
		end
	end

	always_ff @(posedge clock) begin
		if (fill.beat_valid) begin
			words[wr_index][fill.word_offset] <= fill.beat_data;
			if (fill.last) begin
				tags[wr_index] <= wr_tag;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			lookup_hit <= 1'b0;
		end else begin
			lookup_hit <= valid[rd_index] && tags[rd_index] == rd_tag; // result one cycle after the address
		end
	end

	always_ff @(posedge clock) begin
		lookup_data <= words[rd_index][rd_word];
	end

endmodule

// File: icache/refill_counter.sv
`timescale 1ns/100ps

module refill_counter (
	input logic clock,
	input logic reset,
	refill_if.counter beats,
	input logic start
);

	logic [fetch_pkg::offset_bits-3:0] count;

	// the burst is line aligned, so the beat count is the word offset
	always_ff @(posedge clock) begin
		if (reset || start) begin
			count <= '0;
		end else if (beats.beat_valid) begin
			count <= count + 1'b1;
		end
	end

	assign beats.word_offset = count;

	// counted on its own so it can be checked against rlast
	assign beats.last = beats.beat_valid && count == (fetch_pkg::words_per_line - 1);

endmodule

// File: verilog/fetch_ctrl.sv
`timescale 1ns/100ps

module fetch_ctrl (
	input logic clock,
	input logic reset,
	refill_if.ctrl refill,
	output logic [31:0] lookup_addr,
	input logic lookup_hit,
	input logic [31:0] lookup_data,
	output logic [31:0] araddr,
	output logic arvalid,
	input logic arready,
	output logic [1:0] arburst,
	output logic [3:0] arlen,
	input logic [31:0] rdata,
	input logic rlast,
	input logic rvalid,
	output logic inst_valid,
	input logic inst_ready,
	output logic [31:0] inst,
	output logic [31:0] pc,
	input logic redirect_valid,
	input logic [31:0] redirect_addr
);

	fetch_pkg::fetch_state_t state, state_d;
	logic [31:0] fetch_pc, fetch_pc_d, pc_step;
	logic [31:0] target, resume_pc;
	logic redir_pending, pending_d;
	logic lookup_done; // array output now belongs to fetch_pc
	logic sent; // the missed word already went to decode
	logic [31:0] held_inst;
	logic [31:0] got_data;
	logic out_free, beat_done, got_word, finish, delivered, load_now, in_cache;

	function automatic logic cacheable(input logic [31:0] addr);
		return addr >= fetch_pkg::sdram_base && addr < fetch_pkg::sdram_limit;
	endfunction

	function automatic fetch_pkg::fetch_state_t first_state(input logic [31:0] addr);
		return cacheable(addr) ? fetch_pkg::lookup : fetch_pkg::io_req;
	endfunction

	assign in_cache = cacheable(fetch_pc);
	assign pc_step = fetch_pc + 32'd4;
	assign resume_pc = redirect_valid ? redirect_addr : target;
	assign out_free = !inst_valid || inst_ready;
	assign beat_done = rvalid && rlast;

	assign lookup_addr = fetch_pc;
	assign arvalid = state == fetch_pkg::miss_req || state == fetch_pkg::io_req;
	assign araddr = in_cache ? (fetch_pc & ~32'(fetch_pkg::line_bytes - 1)) : fetch_pc;
	assign arburst = in_cache ? axi_pkg::burst_incr : axi_pkg::burst_fixed;
	assign arlen = in_cache ? axi_pkg::refill_len : 4'd0;

	// a cached burst still fills its line while draining after a redirect
	assign refill.beat_valid = rvalid && (state == fetch_pkg::miss_fill ||
		(state == fetch_pkg::drain && in_cache));
	assign refill.beat_data = rdata;
	assign refill.line_addr = fetch_pc[31:fetch_pkg::offset_bits];

	always_comb begin
		got_word = 1'b0;
		got_data = rdata;
		finish = 1'b0;
		case (state)
			fetch_pkg::lookup: begin
				got_word = lookup_done && lookup_hit;
				got_data = lookup_data;
				finish = got_word;
			end
			fetch_pkg::miss_fill: begin
				got_word = rvalid && refill.word_offset == fetch_pc[fetch_pkg::offset_bits-1:2];
				finish = beat_done;
			end
			fetch_pkg::io_wait: begin
				got_word = rvalid;
				finish = beat_done;
			end
			default: begin
			end
		endcase
	end

	assign delivered = sent || (got_word && out_free);
	assign load_now = !redirect_valid && out_free && (got_word || state == fetch_pkg::hold);

	always_comb begin
		state_d = state;
		fetch_pc_d = fetch_pc;
		pending_d = redir_pending || redirect_valid;
		case (state)
			fetch_pkg::idle: state_d = first_state(fetch_pc);
			fetch_pkg::miss_req, fetch_pkg::io_req: begin
				if (arready) begin
					if (pending_d) begin
						state_d = fetch_pkg::drain;
					end else begin
						state_d = state == fetch_pkg::miss_req ? fetch_pkg::miss_fill : fetch_pkg::io_wait;
					end
				end
			end
			fetch_pkg::lookup, fetch_pkg::miss_fill, fetch_pkg::io_wait: begin
				if (state == fetch_pkg::lookup && lookup_done && !lookup_hit) begin
					state_d = fetch_pkg::miss_req;
				end else if (pending_d && state != fetch_pkg::lookup) begin
					state_d = fetch_pkg::drain;
				end else if (finish && delivered) begin
					fetch_pc_d = pc_step;
					state_d = first_state(pc_step);
				end else if (finish) begin
					state_d = fetch_pkg::hold; // decode is still busy with the previous one
				end
			end
			fetch_pkg::hold: begin
				if (out_free) begin
					fetch_pc_d = pc_step;
					state_d = first_state(pc_step);
				end
			end
			default: begin
			end
		endcase
		// restart at the redirect target once no read beats are outstanding
		if (pending_d && (state inside {fetch_pkg::idle, fetch_pkg::lookup, fetch_pkg::hold} ||
			(state inside {fetch_pkg::miss_fill, fetch_pkg::io_wait, fetch_pkg::drain} && beat_done))) begin
			fetch_pc_d = resume_pc;
			state_d = first_state(resume_pc);
			pending_d = 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= fetch_pkg::idle;
			fetch_pc <= fetch_pkg::reset_pc;
			redir_pending <= 1'b0;
			lookup_done <= 1'b0;
			sent <= 1'b0;
			inst_valid <= 1'b0;
		end else begin
			state <= state_d;
			fetch_pc <= fetch_pc_d;
			redir_pending <= pending_d;
			lookup_done <= state == fetch_pkg::lookup && !lookup_done && !redirect_valid;
			sent <= state == fetch_pkg::miss_fill && !finish && (sent || load_now);
			if (redirect_valid) begin
				inst_valid <= 1'b0;
			end else if (load_now) begin
				inst_valid <= 1'b1;
			end else if (inst_ready) begin
				inst_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (load_now) begin
			inst <= state == fetch_pkg::hold ? held_inst : got_data;
			pc <= fetch_pc;
		end
		if (got_word && !out_free) begin
			held_inst <= got_data;
		end
		if (redirect_valid) begin
			target <= redirect_addr;
		end
	end

endmodule

// File: verilog/ifetch_top.sv
`timescale 1ns/100ps

module ifetch_top (
	input logic clock,
	input logic reset,
	output logic [31:0] araddr,
	output logic arvalid,
	input logic arready,
	output logic [1:0] arburst,
	output logic [3:0] arlen,
	input logic [31:0] rdata,
	input logic [1:0] rresp,
	input logic rlast,
	input logic rvalid,
	output logic rready,
	output logic inst_valid,
	input logic inst_ready,
	output logic [31:0] inst,
	output logic [31:0] pc,
	input logic redirect_valid,
	input logic [31:0] redirect_addr
);

	logic [31:0] lookup_addr;
	logic lookup_hit;
	logic [31:0] lookup_data;

	refill_if refill ();

	assign rready = 1'b1; // read data is never back-pressured

	fetch_ctrl u_ctrl (
		.clock(clock),
		.reset(reset),
		.refill(refill.ctrl),
		.lookup_addr(lookup_addr),
		.lookup_hit(lookup_hit),
		.lookup_data(lookup_data),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.arburst(arburst),
		.arlen(arlen),
		.rdata(rdata),
		.rlast(rlast),
		.rvalid(rvalid),
		.inst_valid(inst_valid),
		.inst_ready(inst_ready),
		.inst(inst),
		.pc(pc),
		.redirect_valid(redirect_valid),
		.redirect_addr(redirect_addr)
	);

	refill_counter u_counter (
		.clock(clock),
		.reset(reset),
		.beats(refill.counter),
		.start(arvalid && arready)
	);

	icache_array u_array (
		.clock(clock),
		.reset(reset),
		.fill(refill.array),
		.lookup_addr(lookup_addr),
		.lookup_hit(lookup_hit),
		.lookup_data(lookup_data)
	);

endmodule

// File: test/ifetch_sva.sv
`timescale 1ns/100ps

module ifetch_sva (
	input logic clock,
	input logic reset,
	input logic arvalid,
	input logic arready,
	input logic [31:0] araddr,
	input logic rvalid,
	input logic rlast,
	input logic [1:0] rresp,
	input logic beat_valid,
	input logic refill_last,
	input logic inst_valid,
	input logic inst_ready,
	input logic redirect_valid,
	input logic [31:0] inst,
	input logic [31:0] pc,
	input fetch_pkg::fetch_state_t state
);

	ar_hold: assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr)) else $error("AR dropped or changed");

	redir_drain: assert property (@(posedge clock) disable iff (reset)
		redirect_valid && !(rvalid && rlast) &&
		state inside {fetch_pkg::miss_fill, fetch_pkg::io_wait} |=> state == fetch_pkg::drain)
		else $error("redirect left an open burst");

	// counted last beat and the bus rlast must agree on a line fill
	last_agree: assert property (@(posedge clock) disable iff (reset)
		beat_valid |-> refill_last == rlast) else $error("refill last differs from rlast");

	out_hold: assert property (@(posedge clock) disable iff (reset)
		inst_valid && !inst_ready && !redirect_valid |=> inst_valid && $stable(inst) && $stable(pc))
		else $error("decode output changed while stalled");

	resp_ok: assert property (@(posedge clock) disable iff (reset)
		rvalid |-> rresp == axi_pkg::resp_okay) else $error("read response not okay");

endmodule

bind ifetch_top ifetch_sva sva (
	.clock(clock),
	.reset(reset),
	.arvalid(arvalid),
	.arready(arready),
	.araddr(araddr),
	.rvalid(rvalid),
	.rlast(rlast),
	.rresp(rresp),
	.beat_valid(refill.beat_valid),
	.refill_last(refill.last),
	.inst_valid(inst_valid),
	.inst_ready(inst_ready),
	.redirect_valid(redirect_valid),
	.inst(inst),
	.pc(pc),
	.state(u_ctrl.state)
);

// File: test/ifetch_tb.sv
`timescale 1ns/100ps

module ifetch_tb;

	logic clock, reset;
	logic [31:0] araddr, rdata, inst, pc, redirect_addr;
	logic arvalid, arready, rlast, rvalid, rready, inst_valid, inst_ready, redirect_valid;
	logic [1:0] arburst, rresp;
	logic [3:0] arlen;

	logic [31:0] pat [0:255]; // images at 0x00 and 0x20, commands from 0x40
	logic [31:0] lfsr;
	int errors, flash_ars, sdram_ars, cycles, limit;

	ifetch_top DUT (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output int v);
		v = 0;
		for (int b = 0; b < n; b++) begin
			v = (v << 1) | int'(lfsr[0]);
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// words outside the image read back as the inverted address
	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		if ((addr & 32'hffff_ff80) == 32'h3000_0000 && addr[6:2] < 5'd24) begin
			return pat[{3'b000, addr[6:2]}];
		end else if ((addr & 32'hffff_ff80) == 32'ha000_0000) begin
			return pat[{3'b001, addr[6:2]}];
		end
		return ~addr;
	endfunction

	task automatic check_ar(input logic [31:0] addr, input logic [1:0] burst,
		input logic [3:0] len);
		if (addr >= 32'ha000_0000 && addr < 32'ha200_0000) begin
			sdram_ars++;
			if (burst != 2'b01 || len != 4'd7 || addr[4:0] != 5'd0) begin
				errors++;
				$display("[FAIL] %0t: sdram AR %h burst %0d len %0d", $time, addr, burst, len);
			end
		end else begin
			flash_ars++;
			if (burst != 2'b00 || len != 4'd0) begin
				errors++;
				$display("[FAIL] %0t: uncached AR %h burst %0d len %0d", $time, addr, burst, len);
			end
		end
	endtask

	task automatic check_inst(input logic [31:0] exp_pc, input logic [31:0] exp_inst);
		if (pc !== exp_pc || inst !== exp_inst) begin
			errors++;
			$display("[FAIL] %0t: got pc %h inst %h, expected pc %h inst %h",
				$time, pc, inst, exp_pc, exp_inst);
		end
	endtask

	initial begin : memory_model
		logic [31:0] addr;
		logic [3:0] len;
		logic [1:0] burst;
		int wait_cycles, gap;
		arready = 1'b0;
		rvalid = 1'b0;
		rlast = 1'b0;
		rdata = '0;
		rresp = 2'b00;
		forever begin
			@(negedge clock);
			if (arvalid && !reset) begin
				draw_bits(2, wait_cycles);
				repeat (wait_cycles) @(negedge clock);
				@(posedge clock);
				#10 arready = 1'b1;
				@(negedge clock);
				addr = araddr;
				len = arlen;
				burst = arburst;
				check_ar(araddr, arburst, arlen);
				@(posedge clock);
				#10 arready = 1'b0;
				for (int beat = 0; beat <= int'(len); beat++) begin
					draw_bits(1, gap);
					if (gap != 0) begin
						rvalid = 1'b0; // idle cycle between beats
						@(posedge clock);
						#10;
					end
					rvalid = 1'b1;
					rdata = mem_word(burst == 2'b01 ? addr + 32'(beat) * 32'd4 : addr);
					rlast = beat == int'(len);
					@(negedge clock);
					if (rready !== 1'b1) begin
						errors++;
						$display("[FAIL] %0t: rready is %b during a read beat", $time, rready);
					end
					@(posedge clock);
					#10;
				end
				rvalid = 1'b0;
				rlast = 1'b0;
			end
		end
	end

	initial begin : watchdog
		cycles = 0;
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", limit);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin : stimulus
		int p, ncmd, got, i, settle, count, total, base_f, base_s;
		logic [31:0] target, mask;
		errors = 0;
		flash_ars = 0;
		sdram_ars = 0;
		limit = 0;
		lfsr = 32'd32071;
		reset = 1'b1;
		inst_ready = 1'b0;
		redirect_valid = 1'b0;
		redirect_addr = '0;
		$readmemh("test/ifetch_patterns.txt", pat);
		ncmd = int'(pat[64]);
		p = 65;
		total = 0;
		for (int c = 0; c < ncmd; c++) begin
			total += int'(pat[p+1]);
			p += 6 + 2 * int'(pat[p+1]);
		end
		limit = 40 * total + 200;
		repeat (8) @(posedge clock);
		#10 reset = 1'b0;
		p = 65;
		for (int c = 0; c < ncmd; c++) begin
			target = pat[p];
			count = int'(pat[p+1]);
			mask = pat[p+2];
			settle = int'(pat[p+3]);
			base_f = flash_ars;
			base_s = sdram_ars;
			if (target != 32'd0) begin
				redirect_valid = 1'b1;
				redirect_addr = target;
				inst_ready = 1'b0; // nothing is taken in the redirect cycle
				@(posedge clock);
				#10 redirect_valid = 1'b0;
			end
			got = 0;
			i = 0;
			while (got < count) begin
				inst_ready = i < 32 ? !mask[i] : 1'b1;
				i++;
				@(negedge clock);
				if (inst_valid && inst_ready) begin
					check_inst(pat[p+6+2*got], pat[p+7+2*got]);
					got++;
				end
				@(posedge clock);
				#10;
			end
			inst_ready = 1'b0;
			repeat (settle) begin
				@(posedge clock);
				#10;
			end
			if (flash_ars - base_f != int'(pat[p+4]) || sdram_ars - base_s != int'(pat[p+5])) begin
				errors++;
				$display("[FAIL] %0t: command %0d saw %0d flash and %0d sdram ARs", $time, c,
					flash_ars - base_f, sdram_ars - base_s);
			end
			p += 6 + 2 * count;
		end
		$display("done: %0d errors, %0d flash ARs, %0d sdram ARs", errors, flash_ars, sdram_ars);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: test/ifetch_patterns.txt
// images: flash words for 0x3000_0000 at @00, sdram words for 0xa000_0000 at @20
// @40 command count, then target count stall_mask settle flash_ars sdram_ars and pc/inst pairs
@00
f0000000 f0000001 f0000002 f0000003 f0000004 f0000005 f0000006 f0000007
f0000008 f0000009 f000000a f000000b f000000c f000000d f000000e f000000f
f0000010 f0000011 f0000012 f0000013 f0000014 f0000015 f0000016 f0000017
@20
5d000000 5d000001 5d000002 5d000003 5d000004 5d000005 5d000006 5d000007
5d000008 5d000009 5d00000a 5d00000b 5d00000c 5d00000d 5d00000e 5d00000f
5d000010 5d000011 5d000012 5d000013 5d000014 5d000015 5d000016 5d000017
5d000018 5d000019 5d00001a 5d00001b 5d00001c 5d00001d 5d00001e 5d00001f
@40
00000005
00000000 00000004 00000000 00000020 00000006 00000000
30000000 f0000000 30000004 f0000001 30000008 f0000002 3000000c f0000003
a0000000 00000008 00000000 00000020 00000000 00000002
a0000000 5d000000 a0000004 5d000001 a0000008 5d000002 a000000c 5d000003
a0000010 5d000004 a0000014 5d000005 a0000018 5d000006 a000001c 5d000007
a0000000 00000008 00000a5c 00000020 00000000 00000000
a0000000 5d000000 a0000004 5d000001 a0000008 5d000002 a000000c 5d000003
a0000010 5d000004 a0000014 5d000005 a0000018 5d000006 a000001c 5d000007
a0000060 00000001 00000000 00000000 00000000 00000001
a0000060 5d000018
30000040 00000003 00000005 00000020 00000005 00000000
30000040 f0000010 30000044 f0000011 30000048 f0000012

// File: ifetch_top.f
common/fetch_pkg.sv
common/axi_pkg.sv
common/refill_if.sv
icache/icache_array.sv
icache/refill_counter.sv
verilog/fetch_ctrl.sv
verilog/ifetch_top.sv
test/ifetch_sva.sv
test/ifetch_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= ifetch_tb
FLIST ?= ifetch_top.f
BUILD ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FLIST))
SIM := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: $(SIM) test/ifetch_patterns.txt
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
